// File: hdl/k5StackPkg.sv
`default_nettype none

package k5StackPkg;

  //------------------------------------------------------------
  // Bus geometry
  //------------------------------------------------------------
  localparam int lpCsrAdrsWidth   = 16;
  localparam int lpBusWidth       = 32;
  localparam int lpBlockSlots     = 16;
  localparam int lpBlockAdrsWidth = $clog2(lpBlockSlots);
  localparam int lpBlockLsb       = 8;
  localparam int lpRegIdxWidth    = 6;
  localparam int lpRegIdxLsb      = 2;
  localparam int lpGpioWidth      = 3;

  //------------------------------------------------------------
  // Block map and register indices
  //------------------------------------------------------------
  // Any unlisted block address decodes to the null block
  typedef enum logic [lpBlockAdrsWidth-1:0] {
    BLK_GPIO  = 'h0,
    BLK_TIMER = 'h4,
    BLK_NULL  = 'hF
  } blockIdT;

  typedef enum logic [lpRegIdxWidth-1:0] {
    GPIO_OUT = 'd0,
    GPIO_DIR = 'd1,
    GPIO_ALT = 'd2,
    GPIO_IN  = 'd3
  } gpioRegT;

  typedef enum logic [lpRegIdxWidth-1:0] {
    TMR_CTRL  = 'd0,
    TMR_COUNT = 'd1,
    TMR_CMP   = 'd2,
    TMR_STAT  = 'd3
  } timerRegT;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    ACK
  } busStateT;

  //------------------------------------------------------------
  // Bus structs
  //------------------------------------------------------------
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [lpCsrAdrsWidth-1:0] adr;
    logic [lpBusWidth-1:0]     dat;
  } wbReqT;

  typedef struct packed {
    logic                  ack;
    logic [lpBusWidth-1:0] dat;
  } wbRspT;

  // One-cycle request toward a single CSR block
  typedef struct packed {
    logic                     valid;
    logic                     we;
    logic [lpRegIdxWidth-1:0] regIdx;
    logic [lpBusWidth-1:0]    wdata;
  } csrReqT;

endpackage

`default_nettype wire

// File: hdl/busSlaveFsm.sv
`default_nettype none

module busSlaveFsm (
  input  logic                             iSCLK,
  input  logic                             qnARST,
  input  k5StackPkg::wbReqT                wbReq,
  output k5StackPkg::wbRspT                wbRsp,
  output k5StackPkg::csrReqT               gpioReq,
  output k5StackPkg::csrReqT               timerReq,
  input  logic [k5StackPkg::lpBusWidth-1:0] gpioRd,
  input  logic [k5StackPkg::lpBusWidth-1:0] timerRd
);

  import k5StackPkg::*;

  busStateT                 state;
  blockIdT                  reqBlk;
  blockIdT                  selBlk;
  logic                     gpioValid;
  logic                     timerValid;
  logic                     reqWe;
  logic [lpRegIdxWidth-1:0] reqIdx;
  logic [lpBusWidth-1:0]    reqData;

  //------------------------------------------------------------
  // Block address decode
  //------------------------------------------------------------
  always_comb
  begin
    case (wbReq.adr[lpBlockLsb +: lpBlockAdrsWidth])
      BLK_GPIO:  reqBlk = BLK_GPIO;
      BLK_TIMER: reqBlk = BLK_TIMER;
      default:   reqBlk = BLK_NULL;
    endcase
  end

  //------------------------------------------------------------
  // Transfer sequencing
  //------------------------------------------------------------
  // Valid is a single-cycle strobe, only toward the decoded block
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      state      <= IDLE;
      selBlk     <= BLK_NULL;
      gpioValid  <= 1'b0;
      timerValid <= 1'b0;
    end
    else
    begin
      gpioValid  <= 1'b0;
      timerValid <= 1'b0;
      case (state)
        IDLE:
        begin
          if (wbReq.cyc && wbReq.stb)
          begin
            state      <= ACCESS;
            selBlk     <= reqBlk;
            gpioValid  <= (reqBlk == BLK_GPIO);
            timerValid <= (reqBlk == BLK_TIMER);
          end
        end
        ACCESS:  state <= ACK;
        ACK:     state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Request payload, captured while waiting for a cycle
  always_ff @(posedge iSCLK)
  begin
    if (state == IDLE)
    begin
      reqWe   <= wbReq.we;
      reqIdx  <= wbReq.adr[lpRegIdxLsb +: lpRegIdxWidth];
      reqData <= wbReq.dat;
    end
  end

  assign gpioReq  = '{valid: gpioValid, we: reqWe, regIdx: reqIdx, wdata: reqData};
  assign timerReq = '{valid: timerValid, we: reqWe, regIdx: reqIdx, wdata: reqData};

  //------------------------------------------------------------
  // Response
  //------------------------------------------------------------
  always_comb
  begin
    wbRsp.ack = (state == ACK);
    case (selBlk)
      BLK_GPIO:  wbRsp.dat = gpioRd;
      BLK_TIMER: wbRsp.dat = timerRd;
      // Null block reads zero
      default:   wbRsp.dat = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/gpioBlock.sv
`default_nettype none

module gpioBlock (
  input  logic                              iSCLK,
  input  logic                              qnARST,
  input  k5StackPkg::csrReqT                csrReq,
  output logic [k5StackPkg::lpBusWidth-1:0]  rdata,
  input  logic [k5StackPkg::lpGpioWidth-1:0] altSrc,
  input  logic [k5StackPkg::lpGpioWidth-1:0] gpioIn,
  output logic [k5StackPkg::lpGpioWidth-1:0] gpioOut,
  output logic [k5StackPkg::lpGpioWidth-1:0] gpioOe
);

  import k5StackPkg::*;

  logic [lpGpioWidth-1:0] outReg;
  logic [lpGpioWidth-1:0] dirReg;
  logic [lpGpioWidth-1:0] altReg;
  logic [lpGpioWidth-1:0] inMeta;
  logic [lpGpioWidth-1:0] inSync;
  logic [lpBusWidth-1:0]  readNext;

  //------------------------------------------------------------
  // Register writes
  //------------------------------------------------------------
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      outReg <= '0;
      dirReg <= '0;
      altReg <= '0;
    end
    else if (csrReq.valid && csrReq.we)
    begin
      case (gpioRegT'(csrReq.regIdx))
        GPIO_OUT: outReg <= csrReq.wdata[lpGpioWidth-1:0];
        GPIO_DIR: dirReg <= csrReq.wdata[lpGpioWidth-1:0];
        GPIO_ALT: altReg <= csrReq.wdata[lpGpioWidth-1:0];
        default:  ;
      endcase
    end
  end

  // Two-flop synchronizer on the pins
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      inMeta <= '0;
      inSync <= '0;
    end
    else
    begin
      inMeta <= gpioIn;
      inSync <= inMeta;
    end
  end

  //------------------------------------------------------------
  // Readback
  //------------------------------------------------------------
  always_comb
  begin
    readNext = '0;
    case (gpioRegT'(csrReq.regIdx))
      GPIO_OUT: readNext[lpGpioWidth-1:0] = outReg;
      GPIO_DIR: readNext[lpGpioWidth-1:0] = dirReg;
      GPIO_ALT: readNext[lpGpioWidth-1:0] = altReg;
      GPIO_IN:  readNext[lpGpioWidth-1:0] = inSync;
      default:  ;
    endcase
  end

  always_ff @(posedge iSCLK)
  begin
    if (csrReq.valid && !csrReq.we)
      rdata <= readNext;
  end

  // Alternate bit picks altSrc per pin
  assign gpioOut = (altReg & altSrc) | (~altReg & outReg);
  assign gpioOe  = dirReg;

endmodule

`default_nettype wire

// File: hdl/sysTimerBlock.sv
`default_nettype none

module sysTimerBlock #(
  parameter int pLedDiv = 25000000
) (
  input  logic                             iSCLK,
  input  logic                             qnARST,
  input  k5StackPkg::csrReqT               csrReq,
  output logic [k5StackPkg::lpBusWidth-1:0] rdata,
  output logic                             matchFlag,
  output logic                             ledToggle
);

  import k5StackPkg::*;

  localparam int lpDivWidth = (pLedDiv > 1) ? $clog2(pLedDiv) : 1;
  localparam logic [lpDivWidth-1:0] lpDivLast = lpDivWidth'(pLedDiv - 1);

  logic                  wrCycle;
  logic                  timerEn;
  logic [lpBusWidth-1:0] count;
  logic [lpBusWidth-1:0] cmpReg;
  logic [lpBusWidth-1:0] readNext;
  logic [lpDivWidth-1:0] divCnt;

  assign wrCycle = csrReq.valid && csrReq.we;

  //------------------------------------------------------------
  // Control and compare registers
  //------------------------------------------------------------
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      timerEn <= 1'b0;
      cmpReg  <= '0;
    end
    else if (wrCycle)
    begin
      case (timerRegT'(csrReq.regIdx))
        TMR_CTRL: timerEn <= csrReq.wdata[0];
        TMR_CMP:  cmpReg  <= csrReq.wdata;
        default:  ;
      endcase
    end
  end

  //------------------------------------------------------------
  // Counter and sticky match
  //------------------------------------------------------------
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      count     <= '0;
      matchFlag <= 1'b0;
    end
    else
    begin
      // Any write to COUNT clears it, regardless of data
      if (wrCycle && timerRegT'(csrReq.regIdx) == TMR_COUNT)
        count <= '0;
      else if (timerEn)
        count <= count + 1'b1;

      // A new match wins over a same-cycle clear
      if (timerEn && count == cmpReg)
        matchFlag <= 1'b1;
      else if (wrCycle && timerRegT'(csrReq.regIdx) == TMR_STAT && csrReq.wdata[0])
        matchFlag <= 1'b0;
    end
  end

  //------------------------------------------------------------
  // Readback
  //------------------------------------------------------------
  always_comb
  begin
    readNext = '0;
    case (timerRegT'(csrReq.regIdx))
      TMR_CTRL:  readNext[0] = timerEn;
      TMR_COUNT: readNext    = count;
      TMR_CMP:   readNext    = cmpReg;
      TMR_STAT:  readNext[0] = matchFlag;
      default:   ;
    endcase
  end

  always_ff @(posedge iSCLK)
  begin
    if (csrReq.valid && !csrReq.we)
      rdata <= readNext;
  end

  //------------------------------------------------------------
  // LED divider
  //------------------------------------------------------------
  // Free running, flips once per pLedDiv clocks
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      divCnt    <= '0;
      ledToggle <= 1'b0;
    end
    else if (divCnt == lpDivLast)
    begin
      divCnt    <= '0;
      ledToggle <= ~ledToggle;
    end
    else
    begin
      divCnt <= divCnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/k5StackTop.sv
`default_nettype none

module k5StackTop #(
  parameter int pLedDiv = 25000000
) (
  input  logic                              iSCLK,
  input  logic                              qnARST,
  input  k5StackPkg::wbReqT                 wbReq,
  output k5StackPkg::wbRspT                 wbRsp,
  input  logic                              pllLocked,
  input  logic [k5StackPkg::lpGpioWidth-1:0] gpioIn,
  output logic [k5StackPkg::lpGpioWidth-1:0] gpioOut,
  output logic [k5StackPkg::lpGpioWidth-1:0] gpioOe
);

  import k5StackPkg::*;

  csrReqT                  gpioReq;
  csrReqT                  timerReq;
  logic [lpBusWidth-1:0]   gpioRd;
  logic [lpBusWidth-1:0]   timerRd;
  logic                    matchFlag;
  logic                    ledToggle;
  logic [lpGpioWidth-1:0]  altSrc;

  //------------------------------------------------------------
  // Wishbone slave and block steering
  //------------------------------------------------------------
  busSlaveFsm uBus (
    .iSCLK    (iSCLK),
    .qnARST   (qnARST),
    .wbReq    (wbReq),
    .wbRsp    (wbRsp),
    .gpioReq  (gpioReq),
    .timerReq (timerReq),
    .gpioRd   (gpioRd),
    .timerRd  (timerRd)
  );

  //------------------------------------------------------------
  // CSR blocks
  //------------------------------------------------------------
  // Alternate sources: pin 0 PLL lock, pin 1 timer match, pin 2 LED
  assign altSrc = {ledToggle, matchFlag, pllLocked};

  gpioBlock uGpio (
    .iSCLK   (iSCLK),
    .qnARST  (qnARST),
    .csrReq  (gpioReq),
    .rdata   (gpioRd),
    .altSrc  (altSrc),
    .gpioIn  (gpioIn),
    .gpioOut (gpioOut),
    .gpioOe  (gpioOe)
  );

  sysTimerBlock #(
    .pLedDiv (pLedDiv)
  ) uTimer (
    .iSCLK     (iSCLK),
    .qnARST    (qnARST),
    .csrReq    (timerReq),
    .rdata     (timerRd),
    .matchFlag (matchFlag),
    .ledToggle (ledToggle)
  );

endmodule

`default_nettype wire

// File: verification/k5Stack_chk.sv
`default_nettype none

module k5StackChk (
  input logic                 iSCLK,
  input logic                 qnARST,
  input k5StackPkg::wbReqT    wbReq,
  input k5StackPkg::wbRspT    wbRsp,
  input k5StackPkg::csrReqT   gpioReq,
  input k5StackPkg::csrReqT   timerReq,
  input k5StackPkg::busStateT state
);
  timeunit 1ns;
  timeprecision 1ps;

  import k5StackPkg::*;

  // Single-cycle ack pulse
  ackPulse: assert property (@(posedge iSCLK) disable iff (!qnARST)
    wbRsp.ack |=> !wbRsp.ack)
    else $error("wbRsp.ack stayed high for more than one cycle");

  // Sampled request, one ACCESS cycle, then ack
  ackLatency: assert property (@(posedge iSCLK) disable iff (!qnARST)
    (state == IDLE && wbReq.cyc && wbReq.stb)
      |=> (state == ACCESS && !wbRsp.ack) ##1 wbRsp.ack)
    else $error("wbRsp.ack did not follow the ACCESS cycle");

  validOneHot: assert property (@(posedge iSCLK) disable iff (!qnARST)
    $onehot0({gpioReq.valid, timerReq.valid}))
    else $error("more than one CSR request valid");

  resetState: assert property (@(posedge iSCLK)
    !qnARST |-> (!wbRsp.ack && !gpioReq.valid && !timerReq.valid))
    else $error("bus outputs active during reset");

endmodule

bind busSlaveFsm k5StackChk uChk (
  .iSCLK    (iSCLK),
  .qnARST   (qnARST),
  .wbReq    (wbReq),
  .wbRsp    (wbRsp),
  .gpioReq  (gpioReq),
  .timerReq (timerReq),
  .state    (state)
);

`default_nettype wire

// File: verification/k5StackTb.sv
`default_nettype none

module k5StackTb;
  timeunit 1ns;
  timeprecision 1ps;

  import k5StackPkg::*;

  localparam int lpLedDiv     = 10;
  localparam int lpAckEdges   = 2;
  localparam int lpAckLimit   = 8;
  localparam int lpTableLen   = 16;
  // Far above the summed length of the table, pin, timer and LED tests
  localparam int lpCycleLimit = 4000;

  typedef struct packed {
    logic        isWrite;
    logic [15:0] adr;
    logic [31:0] wdata;
    logic [31:0] expVal;
    logic [31:0] mask;
  } tableEntryT;

  logic                   iSCLK;
  logic                   qnARST;
  wbReqT                  wbReq;
  wbRspT                  wbRsp;
  logic                   pllLocked;
  logic [lpGpioWidth-1:0] gpioIn;
  logic [lpGpioWidth-1:0] gpioOut;
  logic [lpGpioWidth-1:0] gpioOe;
  logic [31:0]            rngState = 32'd27;
  int                     errCount = 0;
  int                     checkCount = 0;
  int                     cycleCount = 0;

  // Columns are write, address, write data, expected read and compare mask
  // GPIO lives in block 0 (OUT 000, DIR 004, ALT 008, IN 00C) and the timer in block 4
  tableEntryT regTable [lpTableLen] = '{
    '{1'b1, 16'h0000, 32'hFFFF_FFF5, 32'h0000_0000, 32'h0000_0000},
    '{1'b0, 16'h0000, 32'h0000_0000, 32'h0000_0005, 32'hFFFF_FFFF},
    '{1'b1, 16'h0004, 32'h0000_0006, 32'h0000_0000, 32'h0000_0000},
    '{1'b0, 16'h0004, 32'h0000_0000, 32'h0000_0006, 32'hFFFF_FFFF},
    '{1'b1, 16'h0008, 32'hFFFF_FFFB, 32'h0000_0000, 32'h0000_0000},
    '{1'b0, 16'h0008, 32'h0000_0000, 32'h0000_0003, 32'hFFFF_FFFF},
    '{1'b1, 16'h0408, 32'h1234_5678, 32'h0000_0000, 32'h0000_0000},
    '{1'b0, 16'h0408, 32'h0000_0000, 32'h1234_5678, 32'hFFFF_FFFF},
    '{1'b1, 16'h0400, 32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0000},
    '{1'b0, 16'h0400, 32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF},
    // Unmapped block writes leave the mapped OUT and CMP registers alone
    '{1'b1, 16'h0100, 32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0000},
    '{1'b1, 16'h0F08, 32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0000},
    '{1'b0, 16'h0200, 32'h0000_0000, 32'h0000_0000, 32'hFFFF_FFFF},
    '{1'b0, 16'h1F08, 32'h0000_0000, 32'h0000_0000, 32'hFFFF_FFFF},
    '{1'b0, 16'h0000, 32'h0000_0000, 32'h0000_0005, 32'hFFFF_FFFF},
    '{1'b0, 16'h0408, 32'h0000_0000, 32'h1234_5678, 32'hFFFF_FFFF}
  };

  k5StackTop #(.pLedDiv(lpLedDiv)) u_dut (.*);

  initial
  begin
    iSCLK = 1'b0;
    forever #20 iSCLK = ~iSCLK;
  end

  initial
  begin
    while (cycleCount < lpCycleLimit)
    begin
      @(posedge iSCLK);
      cycleCount++;
    end
    $display("Timeout: run did not finish within %0d cycles", lpCycleLimit);
    $display("SIMULATION FAILED");
    $finish;
  end

  //------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    assert (got === exp)
    else
    begin
      $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      errCount++;
    end
  endtask

  // One classic cycle with read data taken while ack is high
  task automatic wbTransfer(input logic isWrite, input logic [15:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int   edges;
    logic ackSeen;
    edges   = 0;
    ackSeen = 1'b0;
    @(posedge iSCLK);
    wbReq <= '{cyc: 1'b1, stb: 1'b1, we: isWrite, adr: adr, dat: wdata};
    while (!ackSeen && edges < lpAckLimit)
    begin
      @(posedge iSCLK);
      edges++;
      @(negedge iSCLK);
      ackSeen = wbRsp.ack;
    end
    rdata = wbRsp.dat;
    checkCount++;
    assert (ackSeen)
    else
    begin
      $display("No ack for address %h within %0d cycles", adr, lpAckLimit);
      errCount++;
    end
    if (ackSeen)
      checkValue("wbRsp.ack latency", edges, lpAckEdges);
    @(posedge iSCLK);
    wbReq <= '0;
  endtask

  task automatic readExpect(input logic [15:0] adr, input logic [31:0] exp);
    logic [31:0] rd;
    wbTransfer(1'b0, adr, 32'h0, rd);
    checkValue($sformatf("wbRsp.dat (adr %h)", adr), rd, exp);
  endtask

  task automatic applyTable(input int first, input int last);
    logic [31:0] rd;
    for (int i = first; i <= last; i++)
    begin
      wbTransfer(regTable[i].isWrite, regTable[i].adr, regTable[i].wdata, rd);
      if (!regTable[i].isWrite)
        checkValue($sformatf("wbRsp.dat (adr %h)", regTable[i].adr),
                   rd & regTable[i].mask, regTable[i].expVal & regTable[i].mask);
    end
  endtask

  //------------------------------------------------------------
  // Test sequence
  //------------------------------------------------------------
  initial
  begin
    int          errBefore;
    int          lastEdge;
    int          toggles;
    logic        ledPrev;
    logic [31:0] rd;
    logic [31:0] cnt0;
    logic [31:0] cnt1;
    wbReq     = '0;
    pllLocked = 1'b0;
    gpioIn    = '0;
    qnARST    = 1'b0;
    repeat (5) @(posedge iSCLK);
    qnARST <= 1'b1;
    @(negedge iSCLK);
    checkValue("wbRsp.ack", wbRsp.ack, 32'h0);
    checkValue("gpioOe", gpioOe, 32'h0);

    errBefore = errCount;
    applyTable(0, 9);
    $display("Test 1 register readback: %s", (errCount == errBefore) ? "ok" : "errors");
    errBefore = errCount;
    applyTable(10, lpTableLen - 1);
    $display("Test 2 null block: %s", (errCount == errBefore) ? "ok" : "errors");

    // Pin direction, output data, PLL lock on alternate pin 0 and input sync
    errBefore = errCount;
    wbTransfer(1'b1, 16'h0008, 32'h0, rd);
    wbTransfer(1'b1, 16'h0004, 32'h5, rd);
    wbTransfer(1'b1, 16'h0000, 32'h3, rd);
    @(negedge iSCLK);
    checkValue("gpioOe", gpioOe, 32'h5);
    checkValue("gpioOut", gpioOut, 32'h3);
    wbTransfer(1'b1, 16'h0008, 32'h1, rd);
    for (int k = 0; k < 4; k++)
    begin
      @(posedge iSCLK);
      pllLocked <= ~k[0];
      @(negedge iSCLK);
      checkValue("gpioOut[0]", gpioOut[0], !k[0]);
      checkValue("gpioOut[2:1]", gpioOut[2:1], 32'h1);
    end
    for (int k = 0; k < 6; k++)
    begin
      rngState = xorshift32(rngState);
      @(posedge iSCLK);
      gpioIn <= rngState[2:0];
      repeat (3) @(posedge iSCLK);
      readExpect(16'h000C, {29'd0, rngState[2:0]});
    end
    wbTransfer(1'b1, 16'h0008, 32'h0, rd);
    $display("Test 3 GPIO pins: %s", (errCount == errBefore) ? "ok" : "errors");

    errBefore = errCount;
    wbTransfer(1'b1, 16'h0400, 32'h0, rd);
    wbTransfer(1'b0, 16'h0404, 32'h0, cnt0);
    wbTransfer(1'b0, 16'h0404, 32'h0, cnt1);
    checkValue("TMR_COUNT while stopped", cnt1, cnt0);
    wbTransfer(1'b1, 16'h0400, 32'h1, rd);
    repeat (20) @(posedge iSCLK);
    wbTransfer(1'b0, 16'h0404, 32'h0, rd);
    checkCount++;
    assert (rd > cnt1)
    else
    begin
      $display("Error at %0d ns: TMR_COUNT is %h, expected above %h", $time, rd, cnt1);
      errCount++;
    end
    wbTransfer(1'b1, 16'h0404, 32'hFFFF_FFFF, rd);
    wbTransfer(1'b0, 16'h0404, 32'h0, rd);
    checkCount++;
    assert (rd < 10)
    else
    begin
      $display("Error at %0d ns: TMR_COUNT is %h, expected below 10", $time, rd);
      errCount++;
    end
    wbTransfer(1'b1, 16'h0400, 32'h0, rd);
    $display("Test 4 timer run and stop: %s", (errCount == errBefore) ? "ok" : "errors");

    // Compare at 20 with the match flag routed to pin 1
    errBefore = errCount;
    wbTransfer(1'b1, 16'h040C, 32'h1, rd);
    wbTransfer(1'b1, 16'h0408, 32'd20, rd);
    wbTransfer(1'b1, 16'h0404, 32'h0, rd);
    wbTransfer(1'b1, 16'h0008, 32'h2, rd);
    wbTransfer(1'b1, 16'h0400, 32'h1, rd);
    repeat (40) @(posedge iSCLK);
    readExpect(16'h040C, 32'h1);
    @(negedge iSCLK);
    checkValue("gpioOut[1]", gpioOut[1], 32'h1);
    wbTransfer(1'b1, 16'h040C, 32'h1, rd);
    readExpect(16'h040C, 32'h0);
    wbTransfer(1'b1, 16'h0400, 32'h0, rd);
    $display("Test 5 compare match: %s", (errCount == errBefore) ? "ok" : "errors");

    errBefore = errCount;
    wbTransfer(1'b1, 16'h0008, 32'h4, rd);
    @(negedge iSCLK);
    ledPrev  = gpioOut[2];
    lastEdge = -1;
    toggles  = 0;
    for (int n = 1; n <= 6 * lpLedDiv; n++)
    begin
      @(negedge iSCLK);
      if (gpioOut[2] !== ledPrev)
      begin
        if (lastEdge >= 0)
          checkValue("gpioOut[2] toggle spacing", n - lastEdge, lpLedDiv);
        lastEdge = n;
        toggles++;
        ledPrev  = gpioOut[2];
      end
    end
    checkCount++;
    assert (toggles >= 4)
    else
    begin
      $display("LED output toggled only %0d times in the watch window", toggles);
      errCount++;
    end
    $display("Test 6 LED divider: %s", (errCount == errBefore) ? "ok" : "errors");

    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: k5Stack.f
hdl/k5StackPkg.sv
hdl/busSlaveFsm.sv
hdl/gpioBlock.sv
hdl/sysTimerBlock.sv
hdl/k5StackTop.sv
verification/k5Stack_chk.sv
verification/k5StackTb.sv

// File: Makefile
TOP = k5StackTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f k5Stack.f --Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
